/* Bender.yml */
package:
  name: cp0

sources:
  - cp0_pkg.sv
  - cp0_timer.sv
  - cp0_regs.sv
  - cp0_exc_ctrl.sv
  - cp0_top.sv
  - target: test
    files:
      - tb_cp0.sv

/* cp0_exc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_exc_ctrl (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  exc_valid_i,
    input  cp0_pkg::exc_req_t    exc_req_i,
    output logic                 exc_ready_o,
    input  wire                  exl_i,
    input  wire [31:0]           vec_base_i,
    input  wire [31:0]           epc_i,
    output cp0_pkg::exc_upd_t    upd_o,
    output logic                 redirect_valid_o,
    output logic [31:0]          redirect_pc_o,
    input  wire                  redirect_ready_i
);

    logic        accept;
    logic        is_enter;
    logic [31:0] target;
    logic        redirect_valid_q;
    logic [31:0] redirect_pc_q;

    // ------------------------------------------------------------------------
    // request handshake
    // ------------------------------------------------------------------------
    // a slot frees up in the same cycle the waiting redirect is taken
    assign exc_ready_o = !redirect_valid_q || redirect_ready_i;
    assign accept      = exc_valid_i && exc_ready_o;
    assign is_enter    = (exc_req_i.op == cp0_pkg::EXC_ENTER);

    // one-cycle update, applied by the register file at the accepting edge
    always_comb begin
        upd_o.enter          = accept && is_enter;
        upd_o.leave          = accept && !is_enter;
        upd_o.code           = exc_req_i.code;
        upd_o.epc            = exl_i ? epc_i : exc_req_i.epc;  // keep epc when nested
        upd_o.badvaddr       = exc_req_i.badvaddr;
        upd_o.badvaddr_valid = exc_req_i.badvaddr_valid;
    end

    // vector base is the pre-update value
    assign target = is_enter ? (vec_base_i + cp0_pkg::EXC_VEC_OFFSET) : epc_i;

    // ------------------------------------------------------------------------
    // redirect output stage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_valid_q <= 1'b0;
        end else if (accept) begin
            redirect_valid_q <= 1'b1;
        end else if (redirect_ready_i) begin
            redirect_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            redirect_pc_q <= target;  // held until fetch takes it
        end
    end

    assign redirect_valid_o = redirect_valid_q;
    assign redirect_pc_o    = redirect_pc_q;

endmodule

`default_nettype wire

/* cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

    // ------------------------------------------------------------------------
    // register numbers and encodings
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        CP0_INDEX    = 5'd0,
        CP0_ENTRYLO0 = 5'd2,
        CP0_ENTRYLO1 = 5'd3,
        CP0_BADVADDR = 5'd8,
        CP0_COUNT    = 5'd9,
        CP0_ENTRYHI  = 5'd10,
        CP0_COMPARE  = 5'd11,
        CP0_STATUS   = 5'd12,
        CP0_CAUSE    = 5'd13,
        CP0_EPC      = 5'd14,
        CP0_EBASE    = 5'd15
    } cp0_addr_e;

    typedef enum logic {
        EXC_ENTER  = 1'b0,
        EXC_RETURN = 1'b1
    } exc_op_e;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,  // load or fetch address error
        EXC_ADES = 5'd5,  // store address error
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_e;

    // ------------------------------------------------------------------------
    // transfer structs
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic        we;
        cp0_addr_e   addr;
        logic [31:0] data;
    } cp0_wr_t;

    typedef struct packed {
        exc_op_e     op;
        exc_code_e   code;
        logic [31:0] epc;
        logic [31:0] badvaddr;
        logic        badvaddr_valid;
    } exc_req_t;

    typedef struct packed {
        logic        enter;
        logic        leave;
        exc_code_e   code;
        logic [31:0] epc;
        logic [31:0] badvaddr;
        logic        badvaddr_valid;
    } exc_upd_t;

    // ------------------------------------------------------------------------
    // write and read masks
    // ------------------------------------------------------------------------
    localparam logic [31:0] STATUS_WR_MASK  = 32'h0000_0013;  // um, exl, ie
    localparam logic [31:0] STATUS_RD_MASK  = 32'h0000_0013;
    localparam logic [31:0] CAUSE_WR_MASK   = 32'h0000_0300;  // software int bits
    localparam logic [31:0] CAUSE_RD_MASK   = 32'h0000_FF7C;  // ip and exc code
    localparam logic [31:0] EBASE_WR_MASK   = 32'h3FFF_F000;
    localparam logic [31:0] EBASE_RD_MASK   = 32'h3FFF_F000;
    localparam logic [31:0] EBASE_RD_FORCE  = 32'h8000_0000;  // top bits read as 10
    localparam logic [31:0] ENTRYHI_WR_MASK = 32'hFFFF_E000;
    localparam logic [31:0] ENTRYHI_RD_MASK = 32'hFFFF_E000;
    localparam logic [31:0] ENTRYLO_WR_MASK = 32'h3FFF_FFC6;
    localparam logic [31:0] ENTRYLO_RD_MASK = 32'h3FFF_FFC6;
    localparam logic [31:0] INDEX_WR_MASK   = 32'h0000_000F;
    localparam logic [31:0] INDEX_RD_MASK   = 32'h0000_000F;

    // reset values and vector offset
    localparam logic [31:0] STATUS_RST      = 32'h1000_0000;
    localparam logic [31:0] EBASE_RST       = 32'h8000_0000;
    localparam logic [31:0] EXC_VEC_OFFSET  = 32'h0000_0180;

endpackage

`default_nettype wire

/* cp0_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
    input  wire                  clk,
    input  wire                  rst_n,
    input  cp0_pkg::cp0_wr_t     wr_i,
    input  cp0_pkg::exc_upd_t    upd_i,
    input  wire [31:0]           count_i,
    input  wire [31:0]           compare_i,
    input  wire                  timer_int_i,
    input  cp0_pkg::cp0_addr_e   rd_addr_i,
    output logic [31:0]          rd_data_o,
    output logic                 exl_o,
    output logic [31:0]          vec_base_o,
    output logic [31:0]          epc_o,
    output logic                 int_pending_o
);

    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;
    logic [31:0] ebase_q;
    logic [31:0] entryhi_q;
    logic [31:0] entrylo0_q;
    logic [31:0] entrylo1_q;
    logic [31:0] index_q;

    logic        wr_status;
    logic        wr_cause;
    logic        wr_epc;
    logic        wr_ebase;
    logic        wr_entryhi;
    logic        wr_entrylo0;
    logic        wr_entrylo1;
    logic        wr_index;

    logic [31:0] cause_rd;
    logic [31:0] ebase_rd;

    function automatic logic [31:0] masked_write(input logic [31:0] old_val,
                                                 input logic [31:0] new_val,
                                                 input logic [31:0] mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    // ------------------------------------------------------------------------
    // move-to decode
    // ------------------------------------------------------------------------
    assign wr_status   = wr_i.we && (wr_i.addr == cp0_pkg::CP0_STATUS);
    assign wr_cause    = wr_i.we && (wr_i.addr == cp0_pkg::CP0_CAUSE);
    assign wr_epc      = wr_i.we && (wr_i.addr == cp0_pkg::CP0_EPC);
    assign wr_ebase    = wr_i.we && (wr_i.addr == cp0_pkg::CP0_EBASE);
    assign wr_entryhi  = wr_i.we && (wr_i.addr == cp0_pkg::CP0_ENTRYHI);
    assign wr_entrylo0 = wr_i.we && (wr_i.addr == cp0_pkg::CP0_ENTRYLO0);
    assign wr_entrylo1 = wr_i.we && (wr_i.addr == cp0_pkg::CP0_ENTRYLO1);
    assign wr_index    = wr_i.we && (wr_i.addr == cp0_pkg::CP0_INDEX);

    // ------------------------------------------------------------------------
    // register storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q   <= cp0_pkg::STATUS_RST;
            cause_q    <= 32'd0;
            epc_q      <= 32'd0;
            badvaddr_q <= 32'd0;
            ebase_q    <= cp0_pkg::EBASE_RST;
            entryhi_q  <= 32'd0;
            entrylo0_q <= 32'd0;
            entrylo1_q <= 32'd0;
            index_q    <= 32'd0;
        end else begin
            // exception updates take precedence over the move-to path
            if (upd_i.enter) begin
                status_q[1] <= 1'b1;  // exl
            end else if (upd_i.leave) begin
                status_q[1] <= 1'b0;
            end else if (wr_status) begin
                status_q <= masked_write(status_q, wr_i.data, cp0_pkg::STATUS_WR_MASK);
            end

            if (upd_i.enter) begin
                cause_q[6:2] <= upd_i.code;
            end else if (wr_cause) begin
                cause_q <= masked_write(cause_q, wr_i.data, cp0_pkg::CAUSE_WR_MASK);
            end

            if (upd_i.enter) begin
                epc_q <= upd_i.epc;  // ctrl already kept old value under exl
            end else if (wr_epc) begin
                epc_q <= wr_i.data;
            end

            if (upd_i.enter && upd_i.badvaddr_valid) begin
                badvaddr_q <= upd_i.badvaddr;  // read only from the move-to side
            end

            if (wr_ebase) begin
                ebase_q <= masked_write(ebase_q, wr_i.data, cp0_pkg::EBASE_WR_MASK);
            end
            if (wr_entryhi) begin
                entryhi_q <= masked_write(entryhi_q, wr_i.data, cp0_pkg::ENTRYHI_WR_MASK);
            end
            if (wr_entrylo0) begin
                entrylo0_q <= masked_write(entrylo0_q, wr_i.data, cp0_pkg::ENTRYLO_WR_MASK);
            end
            if (wr_entrylo1) begin
                entrylo1_q <= masked_write(entrylo1_q, wr_i.data, cp0_pkg::ENTRYLO_WR_MASK);
            end
            if (wr_index) begin
                index_q <= masked_write(index_q, wr_i.data, cp0_pkg::INDEX_WR_MASK);
            end
        end
    end

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------
    // ip7 comes straight from the timer flag
    assign cause_rd = {cause_q[31:16], timer_int_i, cause_q[14:0]} & cp0_pkg::CAUSE_RD_MASK;
    assign ebase_rd = (ebase_q & cp0_pkg::EBASE_RD_MASK) | cp0_pkg::EBASE_RD_FORCE;

    always_comb begin
        case (rd_addr_i)
            cp0_pkg::CP0_INDEX:    rd_data_o = index_q & cp0_pkg::INDEX_RD_MASK;
            cp0_pkg::CP0_ENTRYLO0: rd_data_o = entrylo0_q & cp0_pkg::ENTRYLO_RD_MASK;
            cp0_pkg::CP0_ENTRYLO1: rd_data_o = entrylo1_q & cp0_pkg::ENTRYLO_RD_MASK;
            cp0_pkg::CP0_BADVADDR: rd_data_o = badvaddr_q;
            cp0_pkg::CP0_COUNT:    rd_data_o = count_i;
            cp0_pkg::CP0_ENTRYHI:  rd_data_o = entryhi_q & cp0_pkg::ENTRYHI_RD_MASK;
            cp0_pkg::CP0_COMPARE:  rd_data_o = compare_i;
            cp0_pkg::CP0_STATUS:   rd_data_o = status_q & cp0_pkg::STATUS_RD_MASK;
            cp0_pkg::CP0_CAUSE:    rd_data_o = cause_rd;
            cp0_pkg::CP0_EPC:      rd_data_o = epc_q;
            cp0_pkg::CP0_EBASE:    rd_data_o = ebase_rd;
            default:               rd_data_o = 32'd0;
        endcase
    end

    assign exl_o      = status_q[1];
    assign vec_base_o = ebase_rd;
    assign epc_o      = epc_q;

    // ie and not exl, any of timer or the two software bits
    assign int_pending_o = status_q[0] && !status_q[1]
                           && (timer_int_i || cause_q[8] || cause_q[9]);

endmodule

`default_nettype wire

/* cp0_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_timer #(
    parameter int unsigned COUNT_STEP = 1
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  cp0_pkg::cp0_wr_t     wr_i,
    output logic [31:0]          count_o,
    output logic [31:0]          compare_o,
    output logic                 timer_int_o
);

    logic [31:0] count_q;
    logic [31:0] compare_q;
    logic        timer_int_q;
    logic        wr_count;
    logic        wr_compare;
    logic        match;

    assign wr_count   = wr_i.we && (wr_i.addr == cp0_pkg::CP0_COUNT);
    assign wr_compare = wr_i.we && (wr_i.addr == cp0_pkg::CP0_COMPARE);
    assign match      = (compare_q != 32'd0) && (compare_q == count_q);  // zero never fires

    // free running counter, a write loads it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= 32'd0;
        end else if (wr_count) begin
            count_q <= wr_i.data;
        end else begin
            count_q <= count_q + 32'(COUNT_STEP);
        end
    end

    // compare register and the sticky interrupt flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            compare_q   <= 32'd0;
            timer_int_q <= 1'b0;
        end else begin
            if (wr_compare) begin
                compare_q   <= wr_i.data;
                timer_int_q <= 1'b0;  // write wins over a match
            end else if (match) begin
                timer_int_q <= 1'b1;
            end
        end
    end

    assign count_o     = count_q;
    assign compare_o   = compare_q;
    assign timer_int_o = timer_int_q;

endmodule

`default_nettype wire

/* cp0_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_top #(
    parameter int unsigned COUNT_STEP = 1
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  cp0_pkg::cp0_wr_t     wr_i,
    input  cp0_pkg::cp0_addr_e   rd_addr_i,
    output logic [31:0]          rd_data_o,
    input  wire                  exc_valid_i,
    input  cp0_pkg::exc_req_t    exc_req_i,
    output logic                 exc_ready_o,
    output logic                 redirect_valid_o,
    output logic [31:0]          redirect_pc_o,
    input  wire                  redirect_ready_i,
    output logic                 timer_int_o,
    output logic                 int_pending_o
);

    logic [31:0]        count;
    logic [31:0]        compare;
    cp0_pkg::exc_upd_t  upd;
    logic               exl;
    logic [31:0]        vec_base;
    logic [31:0]        epc;

    cp0_timer #(
        .COUNT_STEP (COUNT_STEP)
    ) i_cp0_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_i        (wr_i),
        .count_o     (count),
        .compare_o   (compare),
        .timer_int_o (timer_int_o)
    );

    cp0_regs i_cp0_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_i          (wr_i),
        .upd_i         (upd),
        .count_i       (count),
        .compare_i     (compare),
        .timer_int_i   (timer_int_o),
        .rd_addr_i     (rd_addr_i),
        .rd_data_o     (rd_data_o),
        .exl_o         (exl),
        .vec_base_o    (vec_base),
        .epc_o         (epc),
        .int_pending_o (int_pending_o)
    );

    cp0_exc_ctrl i_cp0_exc_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .exc_valid_i      (exc_valid_i),
        .exc_req_i        (exc_req_i),
        .exc_ready_o      (exc_ready_o),
        .exl_i            (exl),
        .vec_base_i       (vec_base),
        .epc_i            (epc),
        .upd_o            (upd),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .redirect_ready_i (redirect_ready_i)
    );

endmodule

`default_nettype wire

/* list.f */
cp0_pkg.sv
cp0_timer.sv
cp0_regs.sv
cp0_exc_ctrl.sv
cp0_top.sv
tb_cp0.sv

/* tb_cp0.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cp0;

    localparam int          CLK_PERIOD   = 100;
    localparam int          DRIVE_DELAY  = 10;
    localparam int          RESET_CYCLES = 8;
    localparam int          WAIT_LIMIT   = 20;
    localparam int          TIMER_OFFSET = 6;
    localparam int unsigned COUNT_STEP   = 1;
    localparam logic [31:0] LFSR_SEED    = 32'd89354;

    // cycle budget of each test, summed for the watchdog
    localparam int RESET_TEST_CYCLES   = 4;
    localparam int MASK_TEST_CYCLES    = 40;
    localparam int TIMER_TEST_CYCLES   = 40;
    localparam int ENTRY_TEST_CYCLES   = 16 + 2 * WAIT_LIMIT;
    localparam int RETURN_TEST_CYCLES  = 8 + 2 * WAIT_LIMIT;
    localparam int PENDING_TEST_CYCLES = 80 + WAIT_LIMIT;
    localparam int MARGIN_CYCLES       = 100;
    localparam int WATCHDOG_CYCLES     = RESET_CYCLES + RESET_TEST_CYCLES + MASK_TEST_CYCLES
                                         + TIMER_TEST_CYCLES + ENTRY_TEST_CYCLES
                                         + RETURN_TEST_CYCLES + PENDING_TEST_CYCLES
                                         + MARGIN_CYCLES;

    // register masks as the register map documents them
    localparam logic [31:0] STATUS_WMASK  = 32'h0000_0013;  // bits 4, 1, 0
    localparam logic [31:0] STATUS_RMASK  = 32'h0000_0013;
    localparam logic [31:0] CAUSE_WMASK   = 32'h0000_0300;  // bits 9:8
    localparam logic [31:0] CAUSE_RMASK   = 32'h0000_FF7C;  // bits 15:8 and 6:2
    localparam logic [31:0] EBASE_MASK    = 32'h3FFF_F000;  // bits 29:12
    localparam logic [31:0] EBASE_TOP     = 32'h8000_0000;  // top bits read as 10
    localparam logic [31:0] ENTRYHI_MASK  = 32'hFFFF_E000;
    localparam logic [31:0] ENTRYLO_MASK  = 32'h3FFF_FFC6;  // bits 29:6 and 2:1
    localparam logic [31:0] INDEX_MASK    = 32'h0000_000F;
    localparam logic [31:0] VECTOR_OFFSET = 32'h0000_0180;

    logic                  clk;
    logic                  rst_n;
    cp0_pkg::cp0_wr_t      wr;
    cp0_pkg::cp0_addr_e    rd_addr;
    logic [31:0]           rd_data;
    logic                  exc_valid;
    cp0_pkg::exc_req_t     exc_req;
    logic                  exc_ready;
    logic                  redirect_valid;
    logic [31:0]           redirect_pc;
    logic                  redirect_ready;
    logic                  timer_int;
    logic                  int_pending;

    logic [31:0]           lfsr_q;
    logic [31:0]           saved_epc;       // values carried from entry to return test
    logic [31:0]           saved_badvaddr;
    logic [31:0]           saved_vector;

    cp0_top #(
        .COUNT_STEP (COUNT_STEP)
    ) i_cp0_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .wr_i             (wr),
        .rd_addr_i        (rd_addr),
        .rd_data_o        (rd_data),
        .exc_valid_i      (exc_valid),
        .exc_req_i        (exc_req),
        .exc_ready_o      (exc_ready),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .redirect_ready_i (redirect_ready),
        .timer_int_o      (timer_int),
        .int_pending_o    (int_pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] result;
        logic        fb;
        int          i;
        result = '0;
        for (i = 0; i < nbits; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            result = {result[30:0], fb};
        end
        return result;
    endfunction

    // readable value after a move-to write
    function automatic logic [31:0] expect_read(input cp0_pkg::cp0_addr_e addr,
                                                input logic [31:0] old_read,
                                                input logic [31:0] data);
        logic [31:0] wmask;
        logic [31:0] rmask;
        logic [31:0] force_bits;
        force_bits = 32'd0;
        case (addr)
            cp0_pkg::CP0_STATUS: begin
                wmask = STATUS_WMASK;
                rmask = STATUS_RMASK;
            end
            cp0_pkg::CP0_CAUSE: begin
                wmask = CAUSE_WMASK;
                rmask = CAUSE_RMASK;
            end
            cp0_pkg::CP0_EBASE: begin
                wmask      = EBASE_MASK;
                rmask      = EBASE_MASK;
                force_bits = EBASE_TOP;
            end
            cp0_pkg::CP0_ENTRYHI: begin
                wmask = ENTRYHI_MASK;
                rmask = ENTRYHI_MASK;
            end
            cp0_pkg::CP0_ENTRYLO0, cp0_pkg::CP0_ENTRYLO1: begin
                wmask = ENTRYLO_MASK;
                rmask = ENTRYLO_MASK;
            end
            cp0_pkg::CP0_INDEX: begin
                wmask = INDEX_MASK;
                rmask = INDEX_MASK;
            end
            default: begin  // epc
                wmask = 32'hFFFF_FFFF;
                rmask = 32'hFFFF_FFFF;
            end
        endcase
        return (((old_read & ~wmask) | (data & wmask)) & rmask) | force_bits;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_word(input cp0_pkg::cp0_addr_e addr,
                                input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: register %0d %s read 0x%08h, expected 0x%08h",
                     $time, addr, addr.name(), got, exp);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_redirect(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: redirect_pc_o is 0x%08h, expected 0x%08h",
                     $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input cp0_pkg::cp0_addr_e addr, input logic [31:0] exp);
        rd_addr = addr;
        #1;
        compare_word(addr, rd_data, exp);
    endtask

    task automatic write_reg(input cp0_pkg::cp0_addr_e addr, input logic [31:0] data);
        wr.we   = 1'b1;
        wr.addr = addr;
        wr.data = data;
        next_cycle();
        wr.we   = 1'b0;
    endtask

    // returns in the cycle after the transfer, valid still driven
    task automatic offer_request(input cp0_pkg::exc_req_t req);
        int waited;
        waited    = 0;
        exc_req   = req;
        exc_valid = 1'b1;
        #1;
        while (!exc_ready && waited < WAIT_LIMIT) begin
            next_cycle();
            #1;
            waited++;
        end
        if (!exc_ready) begin
            $display("exception request was never accepted by the DUT");
            abort_run();
        end else begin
            next_cycle();
        end
    endtask

    task automatic take_redirect(input logic [31:0] exp_pc);
        int waited;
        waited         = 0;
        redirect_ready = 1'b1;
        #1;
        while (!redirect_valid && waited < WAIT_LIMIT) begin
            next_cycle();
            #1;
            waited++;
        end
        if (!redirect_valid) begin
            $display("redirect never became valid");
            abort_run();
        end else begin
            compare_redirect(redirect_pc, exp_pc);
            next_cycle();
            compare_bit("redirect_valid_o after accept", redirect_valid, 1'b0);
        end
    endtask

    task automatic raise_timer();
        int waited;
        waited = 0;
        write_reg(cp0_pkg::CP0_COUNT, 32'd500);
        write_reg(cp0_pkg::CP0_COMPARE, 32'd500 + 3 * COUNT_STEP);
        while (!timer_int && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!timer_int) begin
            $display("timer interrupt did not rise after the compare match");
            abort_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic test_reset_state();
        check_reg(cp0_pkg::CP0_STATUS, 32'd0);  // bit 28 not readable
        check_reg(cp0_pkg::CP0_EBASE, 32'h8000_0000);
        check_reg(cp0_pkg::CP0_COMPARE, 32'd0);
        check_reg(cp0_pkg::CP0_CAUSE, 32'd0);
        compare_bit("timer_int_o", timer_int, 1'b0);
        compare_bit("int_pending_o", int_pending, 1'b0);
        compare_bit("redirect_valid_o", redirect_valid, 1'b0);
        compare_bit("exc_ready_o", exc_ready, 1'b1);
    endtask

    task automatic test_write_masks();
        cp0_pkg::cp0_addr_e regs [8];
        logic [31:0]        shadow [32];
        logic [31:0]        data;
        int                 round;
        int                 i;
        regs = '{cp0_pkg::CP0_STATUS, cp0_pkg::CP0_CAUSE, cp0_pkg::CP0_EPC,
                 cp0_pkg::CP0_EBASE, cp0_pkg::CP0_ENTRYHI, cp0_pkg::CP0_ENTRYLO0,
                 cp0_pkg::CP0_ENTRYLO1, cp0_pkg::CP0_INDEX};
        for (i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
        end
        shadow[cp0_pkg::CP0_EBASE] = 32'h8000_0000;
        for (round = 0; round < 2; round++) begin
            for (i = 0; i < 8; i++) begin
                data = rand_bits(32);
                write_reg(regs[i], data);
                shadow[regs[i]] = expect_read(regs[i], shadow[regs[i]], data);
                check_reg(regs[i], shadow[regs[i]]);
            end
        end
        check_reg(cp0_pkg::cp0_addr_e'(5'd1), 32'd0);  // unmapped numbers
        check_reg(cp0_pkg::cp0_addr_e'(5'd31), 32'd0);
        write_reg(cp0_pkg::CP0_STATUS, 32'd0);
        write_reg(cp0_pkg::CP0_CAUSE, 32'd0);
    endtask

    task automatic test_timer();
        logic [31:0] start;
        int          k;
        start = rand_bits(31);  // keeps compare clear of wrap to zero
        write_reg(cp0_pkg::CP0_COUNT, start);
        check_reg(cp0_pkg::CP0_COUNT, start);
        write_reg(cp0_pkg::CP0_COMPARE, start + COUNT_STEP * (1 + TIMER_OFFSET));
        for (k = 0; k <= TIMER_OFFSET + 1; k++) begin
            check_reg(cp0_pkg::CP0_COUNT, start + COUNT_STEP * (1 + k));
            compare_bit("timer_int_o", timer_int, k > TIMER_OFFSET);
            next_cycle();
        end
        compare_bit("timer_int_o held", timer_int, 1'b1);
        check_reg(cp0_pkg::CP0_CAUSE, 32'h0000_8000);  // ip7 mirrors the flag
        write_reg(cp0_pkg::CP0_COMPARE, 32'd0);
        compare_bit("timer_int_o after compare write", timer_int, 1'b0);

        // compare write in the match cycle
        write_reg(cp0_pkg::CP0_COUNT, 32'd100);
        write_reg(cp0_pkg::CP0_COMPARE, 32'd100 + 3 * COUNT_STEP);
        next_cycle();
        next_cycle();
        check_reg(cp0_pkg::CP0_COUNT, 32'd100 + 3 * COUNT_STEP);
        write_reg(cp0_pkg::CP0_COMPARE, 32'd0);
        compare_bit("timer_int_o with write on match", timer_int, 1'b0);
        next_cycle();
        compare_bit("timer_int_o with write on match", timer_int, 1'b0);

        // compare zero while count wraps through zero
        write_reg(cp0_pkg::CP0_COUNT, 32'hFFFF_FFFD);
        for (k = 0; k < 6; k++) begin
            compare_bit("timer_int_o with compare zero", timer_int, 1'b0);
            next_cycle();
        end
    endtask

    task automatic test_exception_entry();
        cp0_pkg::exc_req_t req;
        logic [31:0]       ebase_val;
        int                k;
        ebase_val      = rand_bits(32);
        saved_epc      = rand_bits(32) & 32'hFFFF_FFFC;
        saved_badvaddr = rand_bits(32);
        saved_vector   = ((ebase_val & EBASE_MASK) | EBASE_TOP) + VECTOR_OFFSET;
        write_reg(cp0_pkg::CP0_EBASE, ebase_val);

        redirect_ready     = 1'b0;
        req.op             = cp0_pkg::EXC_ENTER;
        req.code           = cp0_pkg::EXC_ADEL;
        req.epc            = saved_epc;
        req.badvaddr       = saved_badvaddr;
        req.badvaddr_valid = 1'b1;
        offer_request(req);
        exc_valid = 1'b0;

        for (k = 0; k < 4; k++) begin  // redirect held under back-pressure
            #1;
            compare_bit("redirect_valid_o", redirect_valid, 1'b1);
            compare_bit("exc_ready_o", exc_ready, 1'b0);
            compare_redirect(redirect_pc, saved_vector);
            next_cycle();
        end
        take_redirect(saved_vector);
        redirect_ready = 1'b0;

        check_reg(cp0_pkg::CP0_EPC, saved_epc);
        check_reg(cp0_pkg::CP0_CAUSE, {27'd0, cp0_pkg::EXC_ADEL} << 2);
        check_reg(cp0_pkg::CP0_BADVADDR, saved_badvaddr);
        check_reg(cp0_pkg::CP0_STATUS, 32'h0000_0002);  // exl
    endtask

    task automatic test_return();
        cp0_pkg::exc_req_t req;
        redirect_ready     = 1'b1;
        req.op             = cp0_pkg::EXC_ENTER;
        req.code           = cp0_pkg::EXC_SYS;
        req.epc            = saved_epc + 32'h40;
        req.badvaddr       = rand_bits(32);
        req.badvaddr_valid = 1'b0;
        offer_request(req);

        // nested entry keeps epc and badvaddr
        #1;
        compare_bit("redirect_valid_o", redirect_valid, 1'b1);
        compare_redirect(redirect_pc, saved_vector);
        check_reg(cp0_pkg::CP0_EPC, saved_epc);
        check_reg(cp0_pkg::CP0_BADVADDR, saved_badvaddr);
        check_reg(cp0_pkg::CP0_CAUSE, {27'd0, cp0_pkg::EXC_SYS} << 2);
        check_reg(cp0_pkg::CP0_STATUS, 32'h0000_0002);

        // return taken in the same cycle as the pending redirect
        req.op   = cp0_pkg::EXC_RETURN;
        req.code = cp0_pkg::EXC_INT;
        offer_request(req);
        exc_valid = 1'b0;
        #1;
        compare_bit("redirect_valid_o", redirect_valid, 1'b1);
        compare_redirect(redirect_pc, saved_epc);
        check_reg(cp0_pkg::CP0_STATUS, 32'd0);
        next_cycle();
        compare_bit("redirect_valid_o after return", redirect_valid, 1'b0);
        redirect_ready = 1'b0;
    endtask

    task automatic test_pending_interrupt();
        logic [3:0] combo;
        logic       expected;
        int         t;
        int         i;
        for (t = 0; t < 2; t++) begin
            if (t == 1) begin
                raise_timer();
            end
            for (i = 0; i < 16; i++) begin
                combo = i[3:0];  // ie, exl, sw0, sw1
                write_reg(cp0_pkg::CP0_STATUS, {30'd0, combo[1], combo[0]});
                write_reg(cp0_pkg::CP0_CAUSE, {22'd0, combo[3:2], 8'd0});
                expected = combo[0] && !combo[1] && (t == 1 || combo[2] || combo[3]);
                compare_bit("int_pending_o", int_pending, expected);
                check_reg(cp0_pkg::CP0_CAUSE, {16'd0, t == 1, 5'd0, combo[3:2], 8'd0}
                          | ({27'd0, cp0_pkg::EXC_SYS} << 2));
            end
        end
        write_reg(cp0_pkg::CP0_STATUS, 32'd0);
        write_reg(cp0_pkg::CP0_CAUSE, 32'd0);
        write_reg(cp0_pkg::CP0_COMPARE, 32'd0);
        compare_bit("timer_int_o", timer_int, 1'b0);
        compare_bit("int_pending_o", int_pending, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("watchdog expired: the tests did not finish in time");
        abort_run();
    end

    initial begin
        lfsr_q         = LFSR_SEED;
        rst_n          = 1'b0;
        wr             = '0;
        rd_addr        = cp0_pkg::CP0_STATUS;
        exc_valid      = 1'b0;
        exc_req        = '0;
        redirect_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        test_reset_state();
        test_write_masks();
        test_timer();
        test_exception_entry();
        test_return();
        test_pending_interrupt();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
